// File: Bender.yml
package:
  name: exu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/exu_pkg.sv
      - hdl/csr_pkg.sv
      - hdl/exu_alu.sv
      - hdl/exu_csr_file.sv
      - hdl/exu_sys_unit.sv
      - hdl/exu_stage.sv
      - hdl/exu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_exu_top.sv

// File: hdl/csr_pkg.sv
`default_nettype none

`include "exu_defines.svh"

package csr_pkg;

  // Machine CSRs, plus privileged selectors sharing the same field
  typedef enum logic [11:0] {
    CSR_ECALL    = 12'h000,
    CSR_EBREAK   = 12'h001,
    CSR_MSTATUS  = 12'h300,
    CSR_MRET     = 12'h302,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342
  } csr_addr_e;

  typedef enum logic [3:0] {
    CSR_PRIV = 4'd0,
    CSR_RW   = 4'd1,
    CSR_RS   = 4'd2,
    CSR_RC   = 4'd3,
    CSR_RWI  = 4'd5,
    CSR_RSI  = 4'd6,
    CSR_RCI  = 4'd7
  } csr_func_e;

  typedef struct packed {
    logic [`EXU_XLEN-9:0] hi;
    logic                 mpie;
    logic [2:0]           mid;
    logic                 mie;
    logic [2:0]           lo;
  } csr_mstatus_t;

endpackage

`default_nettype wire

// File: hdl/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_alu
  import exu_pkg::*;
(
  input  exu_alu_op_e          op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = src2_i[5:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $signed(src1_i) >>> shamt;
      // Compares give a single set bit
      ALU_SLT:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      ALU_SGE:  res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exu_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_csr_file
  import csr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  csr_addr_e            addr_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  input  logic                 wen_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  input  logic                 ecall_i,
  input  logic [`EXU_XLEN-1:0] epc_i,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);

  csr_mstatus_t         mstatus;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mcause;
  logic [`EXU_XLEN-1:0] mscratch;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS:  rdata_o = mstatus;
      CSR_MTVEC:    rdata_o = mtvec;
      CSR_MEPC:     rdata_o = mepc;
      CSR_MCAUSE:   rdata_o = mcause;
      CSR_MSCRATCH: rdata_o = mscratch;
      default:      rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else begin
      if (wen_i) begin
        case (addr_i)
          CSR_MSTATUS:  mstatus  <= wdata_i;
          CSR_MTVEC:    mtvec    <= wdata_i;
          CSR_MEPC:     mepc     <= wdata_i;
          CSR_MCAUSE:   mcause   <= wdata_i;
          CSR_MSCRATCH: mscratch <= wdata_i;
          default:      ;
        endcase
      end
      // ECALL saves the trap pc alongside the cause write
      if (ecall_i) begin
        mepc <= epc_i;
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

// File: hdl/exu_pkg.sv
`default_nettype none

`include "exu_defines.svh"

package exu_pkg;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } exu_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SGE  = 4'd10,
    ALU_SGEU = 4'd11
  } exu_alu_op_e;

  // System view of the immediate, as packed by decode
  typedef struct packed {
    logic [`EXU_XLEN-17:0] pad;
    logic [11:0]           csr_addr;
    logic [3:0]            csr_func;
  } exu_sys_imm_t;

  typedef union packed {
    logic [`EXU_XLEN-1:0] raw;
    exu_sys_imm_t         sys;
  } exu_imm_u;

  typedef struct packed {
    exu_opcode_e          opcode;
    exu_alu_op_e          alu_op;
    logic [4:0]           rd;
    logic                 rwen;
    logic                 ren;
    logic                 wen;
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] base;
    exu_imm_u             imm;
  } exu_issue_t;

  typedef struct packed {
    logic [4:0]           rd;
    logic                 rwen;
    logic [`EXU_XLEN-1:0] wdata;
    logic                 redirect;
    logic [`EXU_XLEN-1:0] npc;
    logic                 ebreak;
  } exu_result_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] wdata;
    logic                 wen;
  } exu_mem_req_t;

endpackage

`default_nettype wire

// File: hdl/exu_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_stage
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exu_issue_t           in_issue_i,
  output logic                 in_ready_o,
  output exu_issue_t           held_o,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic                 redirect_i,
  input  logic [`EXU_XLEN-1:0] npc_i,
  input  logic                 ebreak_i,
  output logic                 mem_req_valid_o,
  output exu_mem_req_t         mem_req_o,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output exu_result_t          out_result_o,
  output logic                 commit_o
);

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    HOLD
  } state_e;

  state_e               state;
  exu_issue_t           held;
  logic [`EXU_XLEN-1:0] load_data;
  logic                 mem_done;

  assign mem_done = (held.ren & mem_rvalid_i) | (held.wen & mem_wready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (in_valid_i) begin
            state <= (in_issue_i.ren | in_issue_i.wen) ? MEM_WAIT : HOLD;
          end
        end
        MEM_WAIT: begin
          if (mem_done) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (out_ready_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Issue and load word capture
  always_ff @(posedge clk) begin
    if (state == IDLE && in_valid_i) begin
      held <= in_issue_i;
    end
    if (state == MEM_WAIT && held.ren && mem_rvalid_i) begin
      load_data <= mem_rdata_i;
    end
  end

  assign in_ready_o      = state == IDLE;
  assign mem_req_valid_o = state == MEM_WAIT;
  assign out_valid_o     = state == HOLD;
  assign commit_o        = out_valid_o & out_ready_i;
  assign held_o          = held;

  assign mem_req_o.addr  = held.base + held.imm.raw;
  assign mem_req_o.wdata = held.op2;
  assign mem_req_o.wen   = held.wen;

  always_comb begin
    out_result_o.rd       = held.rd;
    out_result_o.rwen     = held.rwen;
    out_result_o.redirect = redirect_i;
    out_result_o.npc      = npc_i;
    out_result_o.ebreak   = ebreak_i;
    case (held.opcode)
      OPC_LOAD:          out_result_o.wdata = load_data;
      OPC_SYSTEM:        out_result_o.wdata = csr_rdata_i;
      OPC_JAL, OPC_JALR: out_result_o.wdata = held.pc + `EXU_XLEN'(`EXU_ILEN_BYTES);
      default:           out_result_o.wdata = alu_res_i;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exu_sys_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_sys_unit
  import exu_pkg::*;
  import csr_pkg::*;
(
  input  exu_issue_t           held_i,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic [`EXU_XLEN-1:0] mtvec_i,
  input  logic [`EXU_XLEN-1:0] mepc_i,
  input  logic                 commit_i,
  output csr_addr_e            csr_addr_o,
  output logic                 csr_wen_o,
  output logic [`EXU_XLEN-1:0] csr_wdata_o,
  output logic                 ecall_o,
  output logic                 redirect_o,
  output logic [`EXU_XLEN-1:0] npc_o,
  output logic                 ebreak_o
);

  csr_addr_e            sel;
  csr_func_e            func;
  csr_mstatus_t         mstatus_old;
  csr_mstatus_t         mstatus_new;
  logic                 is_sys;
  logic                 is_ecall;
  logic                 is_ebreak;
  logic                 is_mret;
  logic                 wen_raw;
  logic [`EXU_XLEN-1:0] target;

  assign sel       = csr_addr_e'(held_i.imm.sys.csr_addr);
  assign func      = csr_func_e'(held_i.imm.sys.csr_func);
  assign is_sys    = held_i.opcode == OPC_SYSTEM;
  assign is_ecall  = is_sys && func == CSR_PRIV && sel == CSR_ECALL;
  assign is_ebreak = is_sys && func == CSR_PRIV && sel == CSR_EBREAK;
  assign is_mret   = is_sys && func == CSR_PRIV && sel == CSR_MRET;
  assign target    = held_i.base + held_i.imm.raw;

  assign csr_addr_o = is_ecall ? CSR_MCAUSE : is_mret ? CSR_MSTATUS : sel;

  // MRET restores MIE from MPIE and sets MPIE
  always_comb begin
    mstatus_old      = csr_mstatus_t'(csr_rdata_i);
    mstatus_new      = mstatus_old;
    mstatus_new.mie  = mstatus_old.mpie;
    mstatus_new.mpie = 1'b1;
  end

  always_comb begin
    wen_raw     = is_sys;
    csr_wdata_o = '0;
    case (func)
      CSR_RW, CSR_RWI: csr_wdata_o = held_i.op1;
      CSR_RS, CSR_RSI: csr_wdata_o = csr_rdata_i | held_i.op1;
      CSR_RC, CSR_RCI: csr_wdata_o = csr_rdata_i & ~held_i.op1;
      CSR_PRIV: begin
        wen_raw = is_ecall | is_mret;
        if (is_ecall) begin
          csr_wdata_o = `EXU_XLEN'(`EXU_MCAUSE_ECALL);
        end else begin
          csr_wdata_o = mstatus_new;
        end
      end
      default: wen_raw = 1'b0;
    endcase
  end

  assign csr_wen_o = commit_i & wen_raw;
  assign ecall_o   = commit_i & is_ecall;

  always_comb begin
    redirect_o = 1'b0;
    ebreak_o   = 1'b0;
    npc_o      = target;
    case (held_i.opcode)
      OPC_JAL, OPC_JALR: redirect_o = 1'b1;
      // SUB compares for equality, the rest set a bit when taken
      OPC_BRANCH: redirect_o = (held_i.alu_op == ALU_SUB) ? ~|alu_res_i : |alu_res_i;
      OPC_SYSTEM: begin
        if (is_ecall) begin
          redirect_o = 1'b1;
          npc_o      = mtvec_i;
        end else if (is_mret) begin
          redirect_o = 1'b1;
          npc_o      = mepc_i;
        end else if (is_ebreak) begin
          redirect_o = 1'b1;
          ebreak_o   = 1'b1;
          npc_o      = held_i.pc;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_top
  import exu_pkg::*;
  import csr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exu_issue_t           in_issue_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output exu_result_t          out_result_o,
  output logic                 mem_req_valid_o,
  output exu_mem_req_t         mem_req_o,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i
);

  exu_issue_t           held;
  csr_addr_e            csr_addr;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] npc;
  logic                 csr_wen;
  logic                 ecall;
  logic                 redirect;
  logic                 ebreak;
  logic                 commit;

  exu_stage i_exu_stage (
    .clk             (clk),
    .rst             (rst),
    .in_valid_i      (in_valid_i),
    .in_issue_i      (in_issue_i),
    .in_ready_o      (in_ready_o),
    .held_o          (held),
    .alu_res_i       (alu_res),
    .csr_rdata_i     (csr_rdata),
    .redirect_i      (redirect),
    .npc_i           (npc),
    .ebreak_i        (ebreak),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_wready_i    (mem_wready_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_result_o    (out_result_o),
    .commit_o        (commit)
  );

  exu_alu i_exu_alu (
    .op_i   (held.alu_op),
    .src1_i (held.op1),
    .src2_i (held.op2),
    .res_o  (alu_res)
  );

  exu_sys_unit i_exu_sys_unit (
    .held_i      (held),
    .alu_res_i   (alu_res),
    .csr_rdata_i (csr_rdata),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .commit_i    (commit),
    .csr_addr_o  (csr_addr),
    .csr_wen_o   (csr_wen),
    .csr_wdata_o (csr_wdata),
    .ecall_o     (ecall),
    .redirect_o  (redirect),
    .npc_o       (npc),
    .ebreak_o    (ebreak)
  );

  exu_csr_file i_exu_csr_file (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (csr_addr),
    .rdata_o (csr_rdata),
    .wen_i   (csr_wen),
    .wdata_i (csr_wdata),
    .ecall_i (ecall),
    .epc_i   (held.pc),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

endmodule

`default_nettype wire

// File: include/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Data and address width
`define EXU_XLEN 64

// Cause code for an environment call from M-mode
`define EXU_MCAUSE_ECALL 11

// Fixed link offset for jumps
`define EXU_ILEN_BYTES 4

`endif

// File: tb.f
+incdir+include
hdl/exu_pkg.sv
hdl/csr_pkg.sv
hdl/exu_alu.sv
hdl/exu_csr_file.sv
hdl/exu_sys_unit.sv
hdl/exu_stage.sv
hdl/exu_top.sv
testbench/tb_exu_top.sv

// File: testbench/tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module tb_exu_top
  import exu_pkg::*;
  import csr_pkg::*;
;

  typedef logic [`EXU_XLEN-1:0] word_t;

  // About 90 operations at up to 15 cycles each, doubled
  localparam int MAX_CYCLES = 3000;

  logic         clk;
  logic         rst;
  logic         in_valid;
  exu_issue_t   in_issue;
  logic         in_ready;
  logic         out_valid;
  logic         out_ready;
  exu_result_t  out_result;
  logic         mem_req_valid;
  exu_mem_req_t mem_req;
  word_t        mem_rdata;
  logic         mem_rvalid;
  logic         mem_wready;

  integer seed = 32'h7344_30eb;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_bad;
  int     checks;
  int     cycles;
  word_t  last_rdata;
  word_t  mem_words [word_t];

  exu_top i_exu_top (
    .clk             (clk),
    .rst             (rst),
    .in_valid_i      (in_valid),
    .in_issue_i      (in_issue),
    .in_ready_o      (in_ready),
    .out_valid_o     (out_valid),
    .out_ready_i     (out_ready),
    .out_result_o    (out_result),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rdata_i     (mem_rdata),
    .mem_rvalid_i    (mem_rvalid),
    .mem_wready_i    (mem_wready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $finish;
  end

  function automatic word_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Failure at %0t: %s", $time, what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_bad++;
    end
    $display("[%0t] %s finished with %0d errors", $time, name, test_errors);
    test_errors = 0;
  endtask

  // Reference rules for every ALU operation
  function automatic word_t alu_model(input exu_alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[5:0];
      ALU_SRL:  return a >> b[5:0];
      ALU_SRA:  return $signed(a) >>> b[5:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
      ALU_SGE:  return ($signed(a) >= $signed(b)) ? 64'd1 : 64'd0;
      ALU_SGEU: return (a >= b) ? 64'd1 : 64'd0;
      default:  return 64'd0;
    endcase
  endfunction

  function automatic exu_issue_t make_issue(input exu_opcode_e opc, input exu_alu_op_e op,
                                            input word_t a, input word_t b);
    exu_issue_t iss;
    iss        = '0;
    iss.opcode = opc;
    iss.alu_op = op;
    iss.rd     = 5'($random(seed));
    iss.rwen   = 1'b1;
    iss.pc     = rand64() & ~64'h3;
    iss.op1    = a;
    iss.op2    = b;
    return iss;
  endfunction

  function automatic exu_issue_t make_system(input csr_func_e func, input csr_addr_e sel,
                                             input word_t src);
    exu_issue_t iss;
    iss                   = make_issue(OPC_SYSTEM, ALU_ADD, src, 64'h0);
    iss.imm.sys.csr_addr  = sel;
    iss.imm.sys.csr_func  = func;
    return iss;
  endfunction

  // Answers the pending request after 0 to 5 cycles
  task automatic respond_memory();
    int           delay;
    exu_mem_req_t req;
    req   = mem_req;
    delay = $unsigned($random(seed)) % 6;
    repeat (delay) begin
      @(posedge clk);
      require(mem_req_valid === 1'b1, "mem_req_valid_o dropped before the response");
      require(!out_valid, "out_valid_o rose before the memory response");
    end
    if (req.wen) begin
      mem_words[req.addr] = req.wdata;
      mem_wready <= 1'b1;
    end else begin
      if (mem_words.exists(req.addr)) begin
        last_rdata = mem_words[req.addr];
      end else begin
        last_rdata = rand64();
      end
      mem_rdata  <= last_rdata;
      mem_rvalid <= 1'b1;
    end
    @(posedge clk);
    require(!out_valid, "out_valid_o rose in the cycle of the memory response");
    mem_rvalid <= 1'b0;
    mem_wready <= 1'b0;
  endtask

  // Called on a rising edge, returns on the edge of the output transfer
  task automatic execute(input exu_issue_t iss, input int stall, output exu_result_t res,
                         output int lat);
    in_valid <= 1'b1;
    in_issue <= iss;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    in_valid <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      require(!in_ready, "in_ready_o high while an instruction is in flight");
      if (mem_req_valid && !out_valid) begin
        check_value("mem_req_o.addr", iss.base + iss.imm.raw, mem_req.addr);
        require(mem_req.wen === iss.wen, "memory request direction does not match");
        if (iss.wen) begin
          check_value("mem_req_o.wdata", iss.op2, mem_req.wdata);
        end
        respond_memory();
      end
    end while (!out_valid);
    res = out_result;
    check_value("out_result_o.rd", iss.rd, res.rd);
    check_value("out_result_o.rwen", iss.rwen, res.rwen);
    repeat (stall) begin
      @(posedge clk);
      require(out_valid === 1'b1, "out_valid_o dropped while out_ready_i was low");
      require(out_result === res, "result changed while out_ready_i was low");
      require(!in_ready, "in_ready_o rose before the output transfer");
    end
    out_ready <= 1'b1;
    @(posedge clk);
    out_ready <= 1'b0;
  endtask

  task automatic csr_access(input csr_func_e func, input csr_addr_e sel, input word_t src,
                            input int stall, output word_t old);
    exu_result_t res;
    int          lat;
    execute(make_system(func, sel, src), stall, res, lat);
    old = res.wdata;
  endtask

  task automatic reset_state();
    require(in_ready === 1'b1, "in_ready_o is not high after reset");
    require(out_valid === 1'b0, "out_valid_o is not low after reset");
    require(mem_req_valid === 1'b0, "mem_req_valid_o is not low after reset");
    report_test("reset_state");
  endtask

  task automatic alu_operations();
    exu_issue_t  iss;
    exu_result_t res;
    exu_alu_op_e op;
    int          lat;
    word_t       a;
    word_t       b;
    for (int k = 0; k < 12; k++) begin
      op = exu_alu_op_e'(k);
      for (int j = 0; j < 3; j++) begin
        a = rand64();
        b = (j == 2) ? a : rand64();
        iss = make_issue(OPC_OP, op, a, b);
        execute(iss, 0, res, lat);
        check_value("out_result_o.wdata", alu_model(op, a, b), res.wdata);
        check_value("out_result_o.redirect", 64'd0, res.redirect);
        check_value("out_valid_o latency", 64'd1, lat);
      end
    end
    report_test("alu_operations");
  endtask

  task automatic jumps_and_branches();
    exu_issue_t  iss;
    exu_result_t res;
    exu_alu_op_e bops [4];
    int          lat;
    logic        taken;
    word_t       x;
    word_t       y;
    word_t       a;
    word_t       b;
    bops[0] = ALU_SUB;
    bops[1] = ALU_XOR;
    bops[2] = ALU_SLT;
    bops[3] = ALU_SGEU;
    for (int k = 0; k < 2; k++) begin
      iss          = make_issue(k == 0 ? OPC_JAL : OPC_JALR, ALU_ADD, 64'h0, 64'h0);
      iss.base     = (k == 0) ? iss.pc : rand64();
      iss.imm.raw  = rand64() & 64'hFFFF_FFFE;
      execute(iss, 0, res, lat);
      check_value("out_result_o.redirect", 64'd1, res.redirect);
      check_value("out_result_o.npc", iss.base + iss.imm.raw, res.npc);
      check_value("out_result_o.wdata", iss.pc + 64'd4, res.wdata);
    end
    for (int k = 0; k < 4; k++) begin
      x = rand64();
      y = rand64();
      for (int p = 0; p < 3; p++) begin
        a = (p == 2) ? y : x;
        b = (p == 0) ? x : (p == 1) ? y : x;
        case (bops[k])
          ALU_SUB: taken = a == b;
          ALU_XOR: taken = a != b;
          ALU_SLT: taken = $signed(a) < $signed(b);
          default: taken = a >= b;
        endcase
        iss         = make_issue(OPC_BRANCH, bops[k], a, b);
        iss.rwen    = 1'b0;
        iss.base    = iss.pc;
        iss.imm.raw = 64'h0000_0000_0000_0ff0;
        execute(iss, 0, res, lat);
        check_value("out_result_o.redirect", taken, res.redirect);
        if (taken) begin
          check_value("out_result_o.npc", iss.pc + 64'h0ff0, res.npc);
        end
      end
    end
    report_test("jumps_and_branches");
  endtask

  task automatic loads_and_stores();
    exu_issue_t  iss;
    exu_result_t res;
    int          lat;
    word_t       base;
    word_t       data;
    for (int i = 0; i < 3; i++) begin
      base        = rand64() & ~64'h7;
      data        = rand64();
      iss         = make_issue(OPC_STORE, ALU_ADD, 64'h0, data);
      iss.rwen    = 1'b0;
      iss.wen     = 1'b1;
      iss.base    = base;
      iss.imm.raw = 64'(i * 8);
      execute(iss, 0, res, lat);
      iss         = make_issue(OPC_LOAD, ALU_ADD, 64'h0, 64'h0);
      iss.ren     = 1'b1;
      iss.base    = base;
      iss.imm.raw = 64'(i * 8);
      execute(iss, 0, res, lat);
      check_value("out_result_o.wdata", data, res.wdata);
      check_value("out_result_o.redirect", 64'd0, res.redirect);
    end
    // Never written, so the responder makes up the word
    iss         = make_issue(OPC_LOAD, ALU_ADD, 64'h0, 64'h0);
    iss.ren     = 1'b1;
    iss.base    = 64'h0000_0000_0000_1000;
    iss.imm.raw = 64'hFFFF_FFFF_FFFF_FFF8;
    execute(iss, 0, res, lat);
    check_value("out_result_o.wdata", last_rdata, res.wdata);
    report_test("loads_and_stores");
  endtask

  task automatic csr_read_modify_write();
    csr_addr_e sel [2];
    word_t     shadow;
    word_t     val;
    word_t     old;
    sel[0] = CSR_MSCRATCH;
    sel[1] = CSR_MTVEC;
    for (int k = 0; k < 2; k++) begin
      // Both registers still hold their reset value
      shadow = 64'h0;
      val    = rand64();
      csr_access(CSR_RW, sel[k], val, 0, old);
      check_value("out_result_o.wdata", shadow, old);
      shadow = val;
      val    = rand64();
      csr_access(CSR_RS, sel[k], val, 0, old);
      check_value("out_result_o.wdata", shadow, old);
      shadow = shadow | val;
      val    = rand64();
      csr_access(CSR_RC, sel[k], val, 0, old);
      check_value("out_result_o.wdata", shadow, old);
      shadow = shadow & ~val;
      csr_access(CSR_RS, sel[k], 64'h0, 0, old);
      check_value("out_result_o.wdata", shadow, old);
    end
    report_test("csr_read_modify_write");
  endtask

  task automatic privileged_ops();
    exu_issue_t  iss;
    exu_result_t res;
    int          lat;
    word_t       tvec;
    word_t       status;
    word_t       exp_status;
    word_t       old;
    tvec = rand64() & ~64'h3;
    csr_access(CSR_RW, CSR_MTVEC, tvec, 0, old);
    iss = make_system(CSR_PRIV, CSR_ECALL, 64'h0);
    execute(iss, 0, res, lat);
    check_value("out_result_o.redirect", 64'd1, res.redirect);
    check_value("out_result_o.npc", tvec, res.npc);
    csr_access(CSR_RS, CSR_MEPC, 64'h0, 0, old);
    check_value("mepc", iss.pc, old);
    csr_access(CSR_RS, CSR_MCAUSE, 64'h0, 0, old);
    check_value("mcause", 64'd11, old);
    // MIE set and MPIE clear before the return
    status        = 64'h0000_0000_0000_1808;
    exp_status    = status;
    exp_status[3] = status[7];
    exp_status[7] = 1'b1;
    csr_access(CSR_RW, CSR_MSTATUS, status, 0, old);
    execute(make_system(CSR_PRIV, CSR_MRET, 64'h0), 0, res, lat);
    check_value("out_result_o.redirect", 64'd1, res.redirect);
    check_value("out_result_o.npc", iss.pc, res.npc);
    csr_access(CSR_RS, CSR_MSTATUS, 64'h0, 0, old);
    check_value("mstatus", exp_status, old);
    iss = make_system(CSR_PRIV, CSR_EBREAK, 64'h0);
    execute(iss, 0, res, lat);
    check_value("out_result_o.redirect", 64'd1, res.redirect);
    check_value("out_result_o.ebreak", 64'd1, res.ebreak);
    check_value("out_result_o.npc", iss.pc, res.npc);
    report_test("privileged_ops");
  endtask

  task automatic back_pressure();
    exu_result_t res;
    int          lat;
    int          stall;
    word_t       cur;
    word_t       val;
    word_t       old;
    word_t       a;
    word_t       b;
    cur = rand64();
    csr_access(CSR_RW, CSR_MSCRATCH, cur, 0, old);
    for (int i = 0; i < 3; i++) begin
      val   = rand64();
      stall = 1 + $unsigned($random(seed)) % 6;
      csr_access(CSR_RW, CSR_MSCRATCH, val, stall, old);
      check_value("out_result_o.wdata", cur, old);
      csr_access(CSR_RS, CSR_MSCRATCH, 64'h0, 0, old);
      check_value("mscratch", val, old);
      cur   = val;
      a     = rand64();
      b     = rand64();
      stall = 1 + $unsigned($random(seed)) % 6;
      execute(make_issue(OPC_OP, ALU_SUB, a, b), stall, res, lat);
      check_value("out_result_o.wdata", a - b, res.wdata);
    end
    report_test("back_pressure");
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_issue   = '0;
    out_ready  = 1'b0;
    mem_rdata  = '0;
    mem_rvalid = 1'b0;
    mem_wready = 1'b0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    tests_bad   = 0;
    checks      = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    reset_state();
    alu_operations();
    jumps_and_branches();
    loads_and_stores();
    csr_read_modify_write();
    privileged_ops();
    back_pressure();
    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
